// File: bench/valu_golden.hex
// func op_mnr sew mask data0 data1 addr vl be start end expect exp_data
// all hex, one request per line; expect 0 means no response and exp_data is unused
00 0 0 0 11223344556677ff 0000000000000001 00001000 08 ff 1 0 1 1122334455667700
00 0 1 0 0001ffff8000fffe 0001000180000003 00001008 04 ff 0 0 1 0002000000000001
00 4 2 0 ffffffff00000005 0000000100000007 00001010 02 0f 0 0 1 000000000000000c
00 0 3 0 ffffffffffffffff 0000000000000002 00001018 01 ff 0 1 1 0000000000000001
02 0 0 0 0000000000000100 0000000000000001 00002000 08 ff 1 0 1 00000000000001ff
02 0 1 0 1234000000050000 0034000100020001 00002008 04 3c 0 0 1 1200ffff0003ffff
02 0 2 0 0000000a00000000 0000000300000001 00002010 02 f0 0 0 1 00000007ffffffff
02 4 3 0 0000000000000000 0000000000000001 00002018 01 ff 0 1 1 ffffffffffffffff
04 0 0 0 80017f00ff100203 017f80ff00200302 00003000 08 ff 1 0 1 01017f0000100202
05 0 0 0 80017f00ff100203 017f80ff00200302 00003008 08 fe 0 0 1 800180ffff100202
06 0 0 0 80017f00ff100203 017f80ff00200302 00003010 08 7f 0 0 1 807f80ffff200303
07 0 0 0 80017f00ff100203 017f80ff00200302 00003018 08 ff 0 1 1 017f7f0000200303
04 0 1 0 8000000112347fff 7fffffff12358000 00004000 04 ff 1 0 1 7fff000112347fff
05 0 1 0 8000000112347fff 7fffffff12358000 00004008 04 ff 0 0 1 8000ffff12348000
06 0 2 0 8000000000000010 7fffffff00000020 00004010 02 ff 0 0 1 8000000000000020
07 0 2 0 8000000000000010 7fffffff00000020 00004018 02 ff 0 0 1 7fffffff00000020
05 0 3 0 8000000000000000 0000000000000001 00004020 01 ff 0 0 1 8000000000000000
04 0 3 0 8000000000000000 0000000000000001 00004028 01 ff 0 0 1 0000000000000001
07 4 3 0 fffffffffffffffe 0000000000000003 00004030 01 ff 0 1 1 0000000000000003
09 0 0 0 f0f0ff00aa55cc33 ff00f0f00ff03c3c 00005000 08 ff 1 0 1 f000f0000a500c30
0a 0 1 0 f0f0ff00aa55cc33 ff00f0f00ff03c3c 00005008 04 ff 0 0 1 fff0fff0aff5fc3f
0b 4 2 0 f0f0ff00aa55cc33 ff00f0f00ff03c3c 00005010 02 ff 0 0 1 0ff00ff0a5a5f00f
17 0 3 1 0123456789abcdef ffffffffffffffff 00005018 01 ff 0 1 1 0123456789abcdef
17 0 3 0 0123456789abcdef ffffffffffffffff 00005020 01 ff 1 1 0 0000000000000000
3f 0 0 0 1111111111111111 2222222222222222 00005028 08 ff 1 1 0 0000000000000000
00 1 0 0 1111111111111111 2222222222222222 00005030 08 ff 1 1 0 0000000000000000
00 0 0 0 0101010101010101 0202020202020202 00006000 08 ff 1 0 1 0303030303030303
0b 0 3 0 aaaaaaaaaaaaaaaa 5555555555555555 00006008 01 0f 0 0 1 ffffffffffffffff
02 0 1 0 0000000000000000 0001000100010001 00006010 04 f0 0 0 1 ffffffffffffffff
0a 4 2 0 0000000000000000 00000000deadbeef 00006018 02 33 0 0 1 00000000deadbeef
01 0 0 0 1111111111111111 2222222222222222 00006020 08 ff 0 0 0 0000000000000000
07 0 0 0 7f7f7f7f7f7f7f7f 8080808080808080 00006028 08 cc 0 0 1 7f7f7f7f7f7f7f7f
17 4 3 1 fedcba9876543210 0000000000000000 00006030 01 ff 0 1 1 fedcba9876543210

// File: bench/valu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module valu_tb;

    localparam int n_vec      = 33;
    localparam int n_col      = 13;   // fields per golden line
    localparam int latency    = 3;    // falling edges from drive to visible response
    localparam int n_drain    = latency + 3;
    localparam int max_cycles = n_vec + 20;

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    valu_op_pkg::func_t   req_func_id;
    valu_op_pkg::opmnr_t  req_op_mnr;
    valu_cfg_pkg::sew_t   req_sew;
    valu_cfg_pkg::vdata_t req_data0;
    valu_cfg_pkg::vdata_t req_data1;
    valu_cfg_pkg::vaddr_t req_addr;
    valu_cfg_pkg::vl_t    req_vl;
    valu_cfg_pkg::be_t    req_be;
    logic                 req_start;
    logic                 req_end;
    logic                 req_mask;
    logic                 resp_valid;
    valu_cfg_pkg::vdata_t resp_data;
    valu_cfg_pkg::sew_t   resp_sew;
    valu_cfg_pkg::vaddr_t resp_addr;
    valu_cfg_pkg::vl_t    resp_vl;
    valu_cfg_pkg::be_t    resp_be;
    logic                 resp_start;
    logic                 resp_end;

    logic [63:0] golden [n_vec*n_col];
    int          exp_line_q [$];   // golden line of each pending response
    int          exp_due_q  [$];   // cycle where it must show up
    int          cycle_cnt = 0;

    valu_top valu_top_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_on_error();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(string name, valu_cfg_pkg::vdata_t got, valu_cfg_pkg::vdata_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(string name, valu_cfg_pkg::vaddr_t got, valu_cfg_pkg::vaddr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_vl(string name, valu_cfg_pkg::vl_t got, valu_cfg_pkg::vl_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_be(string name, valu_cfg_pkg::be_t got, valu_cfg_pkg::be_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sew(string name, valu_cfg_pkg::sew_t got, valu_cfg_pkg::sew_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic drive_line(int n);
        int b;
        b = n * n_col;
        req_valid   = 1'b1;
        req_func_id = golden[b][5:0];
        req_op_mnr  = golden[b+1][2:0];
        req_sew     = golden[b+2][1:0];
        req_mask    = golden[b+3][0];
        req_data0   = golden[b+4];
        req_data1   = golden[b+5];
        req_addr    = golden[b+6][31:0];
        req_vl      = golden[b+7][7:0];
        req_be      = golden[b+8][7:0];
        req_start   = golden[b+9][0];
        req_end     = golden[b+10][0];
    endtask

    // outputs are stable at the falling edge
    task automatic check_output(int now);
        int b;
        if (resp_valid) begin
            if (exp_line_q.size() == 0) begin
                $display("unexpected resp_valid at %0d ns with no request pending", $time);
                stop_on_error();
            end else if (exp_due_q[0] != now) begin
                $display("response for line %0d came at cycle %0d, due at cycle %0d",
                         exp_line_q[0], now, exp_due_q[0]);
                stop_on_error();
            end else begin
                b = exp_line_q[0] * n_col;
                check_data("resp_data", resp_data, golden[b+12]);
                check_sew("resp_sew", resp_sew, golden[b+2][1:0]);
                check_addr("resp_addr", resp_addr, golden[b+6][31:0]);
                check_vl("resp_vl", resp_vl, golden[b+7][7:0]);
                check_be("resp_be", resp_be, golden[b+8][7:0]);
                check_flag("resp_start", resp_start, golden[b+9][0]);
                check_flag("resp_end", resp_end, golden[b+10][0]);
                void'(exp_line_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end else if (exp_due_q.size() != 0 && exp_due_q[0] <= now) begin
            $display("missing resp_valid for line %0d at %0d ns", exp_line_q[0], $time);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout, run still going after %0d cycles", cycle_cnt);
            stop_on_error();
        end
    end

    initial begin
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_func_id = '0;
        req_op_mnr  = '0;
        req_sew     = '0;
        req_mask    = 1'b0;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_vl      = '0;
        req_be      = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        $readmemh("bench/valu_golden.hex", golden);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < n_vec + n_drain; c++) begin
            @(negedge clk);
            check_output(c);
            if (c < n_vec) begin
                drive_line(c);
                if (golden[c*n_col+11][0]) begin
                    exp_line_q.push_back(c);
                    exp_due_q.push_back(c + latency);
                end
            end else begin
                req_valid = 1'b0;   // drain
            end
        end
        if (exp_line_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_line_q.size());
            stop_on_error();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: build.f
verilog/valu_cfg_pkg.sv
verilog/valu_op_pkg.sv
verilog/valu_issue_if.sv
verilog/op_decode.sv
verilog/add_min_max_unit.sv
verilog/logic_unit.sv
verilog/resp_combine.sv
verilog/valu_top.sv
bench/valu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module valu_tb -o valu_sim

status=0
output=$(./obj_dir/valu_sim 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// File: verilog/add_min_max_unit.sv
`timescale 1ns/1ps
`default_nettype none

module add_min_max_unit (
    input  logic                 clk,
    input  logic                 rst,
    valu_issue_if.unit           issue,
    output logic                 result_valid,
    output valu_cfg_pkg::vdata_t result_data
);

    logic                 is_sub;
    logic                 is_minmax;
    logic                 is_max;
    logic                 is_signed;
    valu_cfg_pkg::vdata_t lane_res [4];   // one full chunk per element width

    assign is_sub    = issue.arith_op == valu_op_pkg::op_sub;
    assign is_max    = (issue.arith_op == valu_op_pkg::op_maxu) ||
                       (issue.arith_op == valu_op_pkg::op_max);
    assign is_minmax = is_max ||
                       (issue.arith_op == valu_op_pkg::op_minu) ||
                       (issue.arith_op == valu_op_pkg::op_min);
    assign is_signed = (issue.arith_op == valu_op_pkg::op_min) ||
                       (issue.arith_op == valu_op_pkg::op_max);

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int ew = 8 << s;

        for (genvar e = 0; e < valu_cfg_pkg::data_w / ew; e++) begin : g_elem
            logic [ew-1:0] a;
            logic [ew-1:0] b;
            logic [ew-1:0] sum;
            logic [ew-1:0] diff;
            logic          lt;

            assign a    = issue.data0[e*ew +: ew];
            assign b    = issue.data1[e*ew +: ew];
            assign sum  = a + b;   // carry dropped at element edge
            assign diff = a - b;
            assign lt   = is_signed ? ($signed(a) < $signed(b)) : (a < b);

            assign lane_res[s][e*ew +: ew] = !is_minmax ? (is_sub ? diff : sum) :
                                             ((lt ^ is_max) ? a : b);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue.arith_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.arith_valid) begin
            result_data <= lane_res[issue.sew];
        end
    end

    a_one_cycle: assert property (@(posedge clk) disable iff (rst)
        issue.arith_valid |=> result_valid);

    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> $past(issue.arith_valid));

endmodule

`default_nettype wire

// File: verilog/logic_unit.sv
`timescale 1ns/1ps
`default_nettype none

module logic_unit (
    input  logic                 clk,
    input  logic                 rst,
    valu_issue_if.unit           issue,
    output logic                 result_valid,
    output valu_cfg_pkg::vdata_t result_data
);

    valu_cfg_pkg::vdata_t logic_res;

    // bitwise, so element width plays no part
    always_comb begin
        case (issue.logic_op)
            valu_op_pkg::op_and: logic_res = issue.data0 & issue.data1;
            valu_op_pkg::op_or:  logic_res = issue.data0 | issue.data1;
            valu_op_pkg::op_xor: logic_res = issue.data0 ^ issue.data1;
            default:             logic_res = issue.data0;   // move
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue.logic_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.logic_valid) begin
            result_data <= logic_res;
        end
    end

endmodule

`default_nettype wire

// File: verilog/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  valu_op_pkg::func_t   req_func_id,
    input  valu_op_pkg::opmnr_t  req_op_mnr,
    input  valu_cfg_pkg::sew_t   req_sew,
    input  valu_cfg_pkg::vdata_t req_data0,
    input  valu_cfg_pkg::vdata_t req_data1,
    input  valu_cfg_pkg::vaddr_t req_addr,
    input  valu_cfg_pkg::vl_t    req_vl,
    input  valu_cfg_pkg::be_t    req_be,
    input  logic                 req_start,
    input  logic                 req_end,
    input  logic                 req_mask,
    valu_issue_if.decoder        issue,
    output logic                 side_valid,
    output valu_cfg_pkg::vaddr_t side_addr,
    output valu_cfg_pkg::vl_t    side_vl,
    output valu_cfg_pkg::be_t    side_be,
    output valu_cfg_pkg::sew_t   side_sew,
    output logic                 side_start,
    output logic                 side_end
);

    logic                   class_ok;
    logic                   arith_hit;
    logic                   logic_hit;
    logic                   arith_go;
    logic                   logic_go;
    logic                   accept;
    valu_op_pkg::arith_op_t arith_sel;
    valu_op_pkg::logic_op_t logic_sel;
    valu_cfg_pkg::sew_t     s1_sew;

    assign class_ok = (req_op_mnr == valu_op_pkg::opmnr_ivv) ||
                      (req_op_mnr == valu_op_pkg::opmnr_ivx);

    always_comb begin
        arith_hit = 1'b0;
        logic_hit = 1'b0;
        arith_sel = valu_op_pkg::op_add;
        logic_sel = valu_op_pkg::op_and;
        case (req_func_id)
            valu_op_pkg::f_add: begin
                arith_hit = 1'b1;
            end
            valu_op_pkg::f_sub: begin
                arith_hit = 1'b1;
                arith_sel = valu_op_pkg::op_sub;
            end
            valu_op_pkg::f_minu: begin
                arith_hit = 1'b1;
                arith_sel = valu_op_pkg::op_minu;
            end
            valu_op_pkg::f_min: begin
                arith_hit = 1'b1;
                arith_sel = valu_op_pkg::op_min;
            end
            valu_op_pkg::f_maxu: begin
                arith_hit = 1'b1;
                arith_sel = valu_op_pkg::op_maxu;
            end
            valu_op_pkg::f_max: begin
                arith_hit = 1'b1;
                arith_sel = valu_op_pkg::op_max;
            end
            valu_op_pkg::f_and: begin
                logic_hit = 1'b1;
            end
            valu_op_pkg::f_or: begin
                logic_hit = 1'b1;
                logic_sel = valu_op_pkg::op_or;
            end
            valu_op_pkg::f_xor: begin
                logic_hit = 1'b1;
                logic_sel = valu_op_pkg::op_xor;
            end
            valu_op_pkg::f_move: begin
                logic_hit = req_mask;   // unmasked form is merge, not handled
                logic_sel = valu_op_pkg::op_move;
            end
            default: begin
            end
        endcase
    end

    assign arith_go = req_valid & class_ok & arith_hit;
    assign logic_go = req_valid & class_ok & logic_hit;
    assign accept   = arith_go | logic_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue.arith_valid <= 1'b0;
            issue.logic_valid <= 1'b0;
            side_valid        <= 1'b0;
        end else begin
            issue.arith_valid <= arith_go;
            issue.logic_valid <= logic_go;
            side_valid        <= accept;
        end
    end

    // stage 1 payload, only loaded for accepted requests
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.arith_op <= arith_sel;
            issue.logic_op <= logic_sel;
            issue.data0    <= req_data0;
            issue.data1    <= req_data1;
            s1_sew         <= req_sew;
            side_addr      <= req_addr;
            side_vl        <= req_vl;
            side_be        <= req_be;
            side_start     <= req_start;
            side_end       <= req_end;
        end
    end

    assign issue.sew = s1_sew;
    assign side_sew  = s1_sew;

    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(issue.arith_valid && issue.logic_valid));

endmodule

`default_nettype wire

// File: verilog/resp_combine.sv
`timescale 1ns/1ps
`default_nettype none

module resp_combine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 arith_valid,
    input  valu_cfg_pkg::vdata_t arith_data,
    input  logic                 logic_valid,
    input  valu_cfg_pkg::vdata_t logic_data,
    input  logic                 side_valid,
    input  valu_cfg_pkg::vaddr_t side_addr,
    input  valu_cfg_pkg::vl_t    side_vl,
    input  valu_cfg_pkg::be_t    side_be,
    input  valu_cfg_pkg::sew_t   side_sew,
    input  logic                 side_start,
    input  logic                 side_end,
    output logic                 resp_valid,
    output valu_cfg_pkg::vdata_t resp_data,
    output valu_cfg_pkg::sew_t   resp_sew,
    output valu_cfg_pkg::vaddr_t resp_addr,
    output valu_cfg_pkg::vl_t    resp_vl,
    output valu_cfg_pkg::be_t    resp_be,
    output logic                 resp_start,
    output logic                 resp_end
);

    logic                 d_valid;
    valu_cfg_pkg::vaddr_t d_addr;
    valu_cfg_pkg::vl_t    d_vl;
    valu_cfg_pkg::be_t    d_be;
    valu_cfg_pkg::sew_t   d_sew;
    logic                 d_start;
    logic                 d_end;
    logic                 unit_valid;

    assign unit_valid = arith_valid | logic_valid;

    // stage 2 copy of the sideband, in step with the unit results
    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= side_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (side_valid) begin
            d_addr  <= side_addr;
            d_vl    <= side_vl;
            d_be    <= side_be;
            d_sew   <= side_sew;
            d_start <= side_start;
            d_end   <= side_end;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
            resp_sew   <= '0;
            resp_addr  <= '0;
            resp_vl    <= '0;
            resp_be    <= '0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            resp_valid <= unit_valid;
            resp_start <= unit_valid & d_start;   // flags only with a response
            resp_end   <= unit_valid & d_end;
            if (unit_valid) begin
                resp_data <= arith_valid ? arith_data : logic_data;
                resp_sew  <= d_sew;
                resp_addr <= d_addr;
                resp_vl   <= d_vl;
                resp_be   <= d_be;
            end
        end
    end

    a_units_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(arith_valid && logic_valid));

    a_side_aligned: assert property (@(posedge clk) disable iff (rst)
        unit_valid == d_valid);

endmodule

`default_nettype wire

// File: verilog/valu_cfg_pkg.sv
`default_nettype none

package valu_cfg_pkg;

    // chunk and sideband widths
    localparam int data_w = 64;
    localparam int addr_w = 32;
    localparam int vl_w   = 8;
    localparam int be_w   = data_w / 8;   // one enable per byte

    typedef logic [data_w-1:0] vdata_t;
    typedef logic [addr_w-1:0] vaddr_t;
    typedef logic [vl_w-1:0]   vl_t;
    typedef logic [be_w-1:0]   be_t;

    // element width, 0 = 8 bit up to 3 = 64 bit
    typedef logic [1:0] sew_t;

endpackage

`default_nettype wire

// File: verilog/valu_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface valu_issue_if;

    logic                   arith_valid;   // strobes, one-hot or idle
    logic                   logic_valid;
    valu_op_pkg::arith_op_t arith_op;
    valu_op_pkg::logic_op_t logic_op;
    valu_cfg_pkg::sew_t     sew;
    valu_cfg_pkg::vdata_t   data0;
    valu_cfg_pkg::vdata_t   data1;

    modport decoder (
        output arith_valid, logic_valid, arith_op, logic_op, sew, data0, data1
    );

    modport unit (
        input arith_valid, logic_valid, arith_op, logic_op, sew, data0, data1
    );

endinterface

`default_nettype wire

// File: verilog/valu_op_pkg.sv
`default_nettype none

package valu_op_pkg;

    typedef logic [5:0] func_t;
    typedef logic [2:0] opmnr_t;

    // function ids as seen on req_func_id
    localparam func_t f_add  = 6'b000000;
    localparam func_t f_sub  = 6'b000010;
    localparam func_t f_minu = 6'b000100;
    localparam func_t f_min  = 6'b000101;
    localparam func_t f_maxu = 6'b000110;
    localparam func_t f_max  = 6'b000111;
    localparam func_t f_and  = 6'b001001;
    localparam func_t f_or   = 6'b001010;
    localparam func_t f_xor  = 6'b001011;
    localparam func_t f_move = 6'b010111;   // only with mask set

    // accepted operand classes
    localparam opmnr_t opmnr_ivv = 3'b000;   // vector-vector
    localparam opmnr_t opmnr_ivx = 3'b100;   // vector-scalar

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_minu,
        op_min,
        op_maxu,
        op_max
    } arith_op_t;

    typedef enum logic [1:0] {
        op_and,
        op_or,
        op_xor,
        op_move
    } logic_op_t;

endpackage

`default_nettype wire

// File: verilog/valu_top.sv
`timescale 1ns/1ps
`default_nettype none

module valu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  valu_op_pkg::func_t   req_func_id,
    input  valu_op_pkg::opmnr_t  req_op_mnr,
    input  valu_cfg_pkg::sew_t   req_sew,
    input  valu_cfg_pkg::vdata_t req_data0,
    input  valu_cfg_pkg::vdata_t req_data1,
    input  valu_cfg_pkg::vaddr_t req_addr,
    input  valu_cfg_pkg::vl_t    req_vl,
    input  valu_cfg_pkg::be_t    req_be,
    input  logic                 req_start,
    input  logic                 req_end,
    input  logic                 req_mask,
    output logic                 resp_valid,
    output valu_cfg_pkg::vdata_t resp_data,
    output valu_cfg_pkg::sew_t   resp_sew,
    output valu_cfg_pkg::vaddr_t resp_addr,
    output valu_cfg_pkg::vl_t    resp_vl,
    output valu_cfg_pkg::be_t    resp_be,
    output logic                 resp_start,
    output logic                 resp_end
);

    logic                 side_valid;
    valu_cfg_pkg::vaddr_t side_addr;
    valu_cfg_pkg::vl_t    side_vl;
    valu_cfg_pkg::be_t    side_be;
    valu_cfg_pkg::sew_t   side_sew;
    logic                 side_start;
    logic                 side_end;
    logic                 arith_valid;
    valu_cfg_pkg::vdata_t arith_data;
    logic                 logic_valid;
    valu_cfg_pkg::vdata_t logic_data;

    valu_issue_if issue_if ();

    op_decode op_decode_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_op_mnr  (req_op_mnr),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_vl      (req_vl),
        .req_be      (req_be),
        .req_start   (req_start),
        .req_end     (req_end),
        .req_mask    (req_mask),
        .issue       (issue_if.decoder),
        .side_valid  (side_valid),
        .side_addr   (side_addr),
        .side_vl     (side_vl),
        .side_be     (side_be),
        .side_sew    (side_sew),
        .side_start  (side_start),
        .side_end    (side_end)
    );

    add_min_max_unit add_min_max_unit_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue_if.unit),
        .result_valid (arith_valid),
        .result_data  (arith_data)
    );

    logic_unit logic_unit_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue_if.unit),
        .result_valid (logic_valid),
        .result_data  (logic_data)
    );

    resp_combine resp_combine_i (
        .clk         (clk),
        .rst         (rst),
        .arith_valid (arith_valid),
        .arith_data  (arith_data),
        .logic_valid (logic_valid),
        .logic_data  (logic_data),
        .side_valid  (side_valid),
        .side_addr   (side_addr),
        .side_vl     (side_vl),
        .side_be     (side_be),
        .side_sew    (side_sew),
        .side_start  (side_start),
        .side_end    (side_end),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_sew    (resp_sew),
        .resp_addr   (resp_addr),
        .resp_vl     (resp_vl),
        .resp_be     (resp_be),
        .resp_start  (resp_start),
        .resp_end    (resp_end)
    );

endmodule

`default_nettype wire
